/* dbg_pkg.sv */
//////////////////////////////
// Debug module package
// Data register layout, command codes, widths and CRC constants
//////////////////////////////
package dbg_pkg;

  // Data register as seen by the module
  localparam int DR_LEN     = 53;
  localparam int WORD_W     = 32;          // SPR data word
  localparam int ADDR_W     = 32;          // Address field and address counter
  localparam int CPU_ADDR_W = 16;          // SPR address, low bits of the counter
  localparam int CNT_W      = 16;          // Word count field
  localparam int BIT_CNT_W  = 6;           // Has to reach 32 for the CRC phase

  // Top bit of each field below the top-level flag
  localparam int OPC_MSB  = DR_LEN - 2;
  localparam int ADDR_MSB = OPC_MSB - 4;
  localparam int CNT_MSB  = ADDR_MSB - ADDR_W;

  // Opcode bit that marks a read burst
  localparam int OPC_RD_BIT = 2;

  // Module commands
  typedef enum logic [3:0] {
    BWRITE32 = 4'h3,
    BREAD32  = 4'h7,
    IREG_WR  = 4'h9
  } opcode_e;

  // Source of the module TDO bit
  typedef enum logic [1:0] {
    TDO_READY,
    TDO_DATA,
    TDO_MATCH,
    TDO_CRC
  } tdo_sel_e;

  // Reflected CRC-32, no final inversion
  localparam logic [WORD_W-1:0] CRC_POLY = 32'hEDB8_8320;
  localparam logic [WORD_W-1:0] CRC_INIT = '1;

endpackage

/* dbg_ctrl_if.sv */
//////////////////////////////
// Burst control bundle
// FSM strobes to the datapath and counter flags back
//////////////////////////////
`timescale 1ns/1ps

interface dbg_ctrl_if;
  import dbg_pkg::*;

  // Counter and register strobes
  logic     addr_ld;
  logic     addr_inc;
  logic     cnt_ld;
  logic     cnt_dec;
  logic     bit_rst;
  logic     bit_en;
  logic     out_ld;
  logic     out_src_biu;     // 1 = bus read word, 0 = status
  logic     out_shift;
  // CRC engine control
  logic     crc_clr;
  logic     crc_en;
  logic     crc_in_tdi;      // Write data from TDI, else read data
  logic     crc_shift;
  tdo_sel_e tdo_sel;

  // Counter flags
  logic     word_zero;
  logic     next_word_zero;  // Count is one
  logic     last_bit;        // Bit count 31
  logic     bit_32;

  modport fsm (
    output addr_ld, addr_inc, cnt_ld, cnt_dec, bit_rst, bit_en, out_ld, out_src_biu,
           out_shift, crc_clr, crc_en, crc_in_tdi, crc_shift, tdo_sel,
    input  word_zero, next_word_zero, last_bit, bit_32
  );

  modport datapath (
    input  addr_ld, addr_inc, cnt_ld, cnt_dec, bit_rst, bit_en, out_ld, out_src_biu,
           out_shift, crc_clr, crc_en, crc_in_tdi, crc_shift, tdo_sel,
    output word_zero, next_word_zero, last_bit, bit_32
  );

endinterface

/* dbg_crc32.sv */
//////////////////////////////
// Serial CRC-32 engine
// One bit per enabled cycle, remainder shifts out LSB first
//////////////////////////////
`timescale 1ns/1ps

module dbg_crc32 (
  input  logic                       tck_i,
  input  logic                       tlr_i,
  input  logic                       clr_i,
  input  logic                       en_i,
  input  logic                       shift_i,
  input  logic                       data_i,
  output logic [dbg_pkg::WORD_W-1:0] crc_o,
  output logic                       serial_o
);
  import dbg_pkg::*;

  logic fb;  // Feedback bit of the reflected form

  assign fb       = crc_o[0] ^ data_i;
  assign serial_o = crc_o[0];

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      crc_o <= CRC_INIT;
    else if (clr_i)
      crc_o <= CRC_INIT;                                   // New burst
    else if (en_i)
      crc_o <= (crc_o >> 1) ^ (fb ? CRC_POLY : '0);
    else if (shift_i)
      crc_o <= {1'b0, crc_o[WORD_W-1:1]};                  // Present next bit on serial_o
  end

endmodule

/* dbg_bus_unit.sv */
//////////////////////////////
// SPR bus interface unit
// One bus transaction per strobe, held until acknowledge
//////////////////////////////
`timescale 1ns/1ps

module dbg_bus_unit (
  input  logic                           tck_i,
  input  logic                           tlr_i,
  input  logic                           strobe_i,
  input  logic                           rd_i,
  input  logic [dbg_pkg::ADDR_W-1:0]     addr_i,
  input  logic [dbg_pkg::WORD_W-1:0]     wdata_i,
  output logic [dbg_pkg::WORD_W-1:0]     rdata_o,
  output logic                           ready_o,
  output logic [dbg_pkg::CPU_ADDR_W-1:0] cpu_addr_o,
  output logic [dbg_pkg::WORD_W-1:0]     cpu_data_o,
  input  logic [dbg_pkg::WORD_W-1:0]     cpu_data_i,
  output logic                           cpu_stb_o,
  output logic                           cpu_we_o,
  input  logic                           cpu_ack_i
);
  import dbg_pkg::*;

  logic busy_q;  // Transaction open on the SPR bus

  assign cpu_stb_o = busy_q;

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
    begin
      busy_q     <= 1'b0;
      ready_o    <= 1'b0;
      cpu_we_o   <= 1'b0;
      cpu_addr_o <= '0;
      cpu_data_o <= '0;
      rdata_o    <= '0;
    end
    else if (strobe_i)
    begin
      // Latch the request, bus strobe rises next cycle
      busy_q     <= 1'b1;
      ready_o    <= 1'b0;
      cpu_we_o   <= ~rd_i;
      cpu_addr_o <= addr_i[CPU_ADDR_W-1:0];                // Only the low bits reach the SPR bus
      cpu_data_o <= wdata_i;
    end
    else if (busy_q && cpu_ack_i)
    begin
      busy_q   <= 1'b0;
      ready_o  <= 1'b1;
      cpu_we_o <= 1'b0;
      if (!cpu_we_o)
        rdata_o <= cpu_data_i;                             // Read word for the next load
    end
  end

  // Burst timing never issues a new request over an open one
  a_no_overlap: assert property (@(posedge tck_i) disable iff (tlr_i)
    strobe_i |-> !busy_q)
    else $error("bus strobe while SPR transaction open");

endmodule

/* dbg_stall_reg.sv */
//////////////////////////////
// CPU stall register
// Set by breakpoint, written by the host
//////////////////////////////
`timescale 1ns/1ps

module dbg_stall_reg (
  input  logic tck_i,
  input  logic tlr_i,
  input  logic we_i,
  input  logic data_i,
  input  logic bp_i,
  output logic stall_o
);

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      stall_o <= 1'b0;
    else if (we_i)
      stall_o <= data_i;    // Host write beats a breakpoint
    else if (bp_i)
      stall_o <= 1'b1;      // Core hit a breakpoint
  end

endmodule

/* dbg_datapath.sv */
//////////////////////////////
// Debug datapath
// Counters, output shift register, CRC and TDO select
//////////////////////////////
`timescale 1ns/1ps

module dbg_datapath (
  input  logic                       tck_i,
  input  logic                       tlr_i,
  input  logic                       tdi_i,
  input  logic [dbg_pkg::DR_LEN-1:0] data_register_i,
  dbg_ctrl_if.datapath               ctrl,
  input  logic                       status_i,
  input  logic [dbg_pkg::WORD_W-1:0] biu_rdata_i,
  input  logic                       biu_ready_i,
  output logic [dbg_pkg::ADDR_W-1:0] addr_o,
  output logic [dbg_pkg::WORD_W-1:0] wdata_o,
  output logic                       tdo_o
);
  import dbg_pkg::*;

  logic [CNT_W-1:0]     cnt_q;       // Words left in the burst
  logic [BIT_CNT_W-1:0] bit_q;
  logic [WORD_W-1:0]    out_q;       // Parallel load, shifts right
  logic [WORD_W-1:0]    crc;
  logic                 crc_din;
  logic                 crc_serial;
  logic                 crc_match;

  ////////////////////////////// Counters
  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
    begin
      addr_o <= '0;
      cnt_q  <= '0;
      bit_q  <= '0;
    end
    else
    begin
      if (ctrl.addr_ld)
        addr_o <= data_register_i[ADDR_MSB -: ADDR_W];
      else if (ctrl.addr_inc)
        addr_o <= addr_o + ADDR_W'(1);                     // SPRs are word addressed
      if (ctrl.cnt_ld)
        cnt_q <= data_register_i[CNT_MSB -: CNT_W];
      else if (ctrl.cnt_dec)
        cnt_q <= cnt_q - CNT_W'(1);
      if (ctrl.bit_rst)
        bit_q <= '0;
      else if (ctrl.bit_en)
        bit_q <= bit_q + BIT_CNT_W'(1);
    end
  end

  assign ctrl.word_zero      = (cnt_q == '0);
  assign ctrl.next_word_zero = (cnt_q == CNT_W'(1));
  assign ctrl.last_bit       = (bit_q == BIT_CNT_W'(WORD_W - 1));
  assign ctrl.bit_32         = (bit_q == BIT_CNT_W'(WORD_W));

  ////////////////////////////// Output register
  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
      out_q <= '0;
    else if (ctrl.out_ld)
      out_q <= ctrl.out_src_biu ? biu_rdata_i : {{(WORD_W-1){1'b0}}, status_i};
    else if (ctrl.out_shift)
      out_q <= {1'b0, out_q[WORD_W-1:1]};
  end

  // Write word completes with the bit still on TDI
  assign wdata_o = {tdi_i, data_register_i[DR_LEN-1 -: WORD_W-1]};

  ////////////////////////////// CRC
  assign crc_din = ctrl.crc_in_tdi ? tdi_i : out_q[0];

  dbg_crc32 u_crc (
    .tck_i    (tck_i),
    .tlr_i    (tlr_i),
    .clr_i    (ctrl.crc_clr),
    .en_i     (ctrl.crc_en),
    .shift_i  (ctrl.crc_shift),
    .data_i   (crc_din),
    .crc_o    (crc),
    .serial_o (crc_serial)
  );

  assign crc_match = (data_register_i[DR_LEN-1 -: WORD_W] == crc);  // Host CRC in top bits

  // TDO source
  always_comb
  begin
    case (ctrl.tdo_sel)
      TDO_READY: tdo_o = biu_ready_i;
      TDO_DATA:  tdo_o = out_q[0];
      TDO_MATCH: tdo_o = crc_match;
      default:   tdo_o = crc_serial;
    endcase
  end

endmodule

/* dbg_burst_fsm.sv */
//////////////////////////////
// Command decoder and burst FSM
// Sequences read and write bursts over the TAP data register
//////////////////////////////
`timescale 1ns/1ps

module dbg_burst_fsm (
  input  logic                       tck_i,
  input  logic                       tlr_i,
  input  logic                       capture_dr_i,
  input  logic                       shift_dr_i,
  input  logic                       update_dr_i,
  input  logic                       module_select_i,
  input  logic [dbg_pkg::DR_LEN-1:0] data_register_i,
  dbg_ctrl_if.fsm                    ctrl,
  input  logic                       biu_ready_i,
  output logic                       biu_strobe_o,
  output logic                       rd_op_o,
  output logic                       stall_we_o,
  output logic                       top_inhibit_o
);
  import dbg_pkg::*;

  typedef enum logic [3:0] {
    ST_IDLE, ST_RBEGIN, ST_RREADY, ST_RSTATUS, ST_RBURST, ST_RCRC,
    ST_WREADY, ST_WWAIT, ST_WBURST, ST_WCRC, ST_WMATCH
  } state_e;

  state_e  state_q;
  state_e  state_d;
  opcode_e opc;
  logic    cmd_hit;     // Update with a module command for us
  logic    burst_cmd;
  logic    rd_q;        // Latched read flag
  logic    load_word;   // Next read word into the output register

  assign opc        = opcode_e'(data_register_i[OPC_MSB -: 4]);
  assign cmd_hit    = module_select_i & update_dr_i & ~data_register_i[DR_LEN-1];
  assign burst_cmd  = (opc == BWRITE32) | (opc == BREAD32);
  assign stall_we_o = (state_q == ST_IDLE) & cmd_hit & (opc == IREG_WR);
  assign rd_op_o    = rd_q;

  always_ff @(posedge tck_i or posedge tlr_i)
  begin
    if (tlr_i)
    begin
      state_q <= ST_IDLE;
      rd_q    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      if (state_q == ST_IDLE && state_d != ST_IDLE)
        rd_q <= opc[OPC_RD_BIT];                           // Direction for the whole burst
    end
  end

  always_comb
  begin
    state_d          = state_q;
    load_word        = 1'b0;
    biu_strobe_o     = 1'b0;
    top_inhibit_o    = 1'b0;
    ctrl.addr_ld     = 1'b0;
    ctrl.addr_inc    = 1'b0;
    ctrl.cnt_ld      = 1'b0;
    ctrl.cnt_dec     = 1'b0;
    ctrl.bit_rst     = 1'b0;
    ctrl.bit_en      = 1'b0;
    ctrl.out_ld      = 1'b0;
    ctrl.out_src_biu = 1'b0;
    ctrl.out_shift   = 1'b0;
    ctrl.crc_clr     = 1'b0;
    ctrl.crc_en      = 1'b0;
    ctrl.crc_in_tdi  = 1'b0;
    ctrl.crc_shift   = 1'b0;
    ctrl.tdo_sel     = TDO_DATA;

    case (state_q)
      ST_IDLE:
      begin
        ctrl.out_ld    = module_select_i & capture_dr_i;  // Status word
        ctrl.out_shift = module_select_i & shift_dr_i;
        if (cmd_hit && burst_cmd)
        begin
          state_d      = opc[OPC_RD_BIT] ? ST_RBEGIN : ST_WREADY;
          ctrl.addr_ld = 1'b1;
          ctrl.cnt_ld  = 1'b1;
          ctrl.bit_rst = 1'b1;
          ctrl.crc_clr = 1'b1;
        end
      end

      ////////////////////////////// Read burst
      ST_RBEGIN:
      begin
        if (update_dr_i || ctrl.word_zero)
          state_d = ST_IDLE;                               // Empty burst
        else
        begin
          state_d       = ST_RREADY;
          biu_strobe_o  = 1'b1;                            // First read goes out now
          ctrl.addr_inc = 1'b1;
        end
      end
      ST_RREADY:
      begin
        if (update_dr_i)
          state_d = ST_IDLE;
        else if (module_select_i && capture_dr_i)
          state_d = ST_RSTATUS;
      end
      ST_RSTATUS:
      begin
        ctrl.tdo_sel  = TDO_READY;                         // Host polls for the ready bit
        top_inhibit_o = 1'b1;
        if (update_dr_i)
          state_d = ST_IDLE;
        else if (shift_dr_i && biu_ready_i)
        begin
          state_d   = ST_RBURST;
          load_word = 1'b1;
        end
      end
      ST_RBURST:
      begin
        top_inhibit_o  = 1'b1;
        ctrl.out_shift = 1'b1;
        ctrl.bit_en    = 1'b1;
        ctrl.crc_en    = 1'b1;                             // CRC over the bit on TDO
        if (update_dr_i)
          state_d = ST_IDLE;
        else if (ctrl.last_bit && ctrl.word_zero)
          state_d = ST_RCRC;
        else if (ctrl.last_bit)
          load_word = 1'b1;
      end
      ST_RCRC:
      begin
        ctrl.tdo_sel   = TDO_CRC;
        ctrl.crc_shift = 1'b1;
        top_inhibit_o  = 1'b1;
        if (update_dr_i)
          state_d = ST_IDLE;
      end

      ////////////////////////////// Write burst
      ST_WREADY:
      begin
        if (update_dr_i || ctrl.word_zero)
          state_d = ST_IDLE;
        else if (module_select_i && capture_dr_i)
          state_d = ST_WWAIT;
      end
      ST_WWAIT:
      begin
        top_inhibit_o = 1'b1;
        if (update_dr_i)
          state_d = ST_IDLE;
        else if (module_select_i && data_register_i[DR_LEN-1])
        begin
          // Start bit reached the MSB, TDI already holds data bit 0
          state_d         = ST_WBURST;
          ctrl.bit_en     = 1'b1;
          ctrl.cnt_dec    = 1'b1;
          ctrl.crc_en     = 1'b1;
          ctrl.crc_in_tdi = 1'b1;
        end
      end
      ST_WBURST:
      begin
        top_inhibit_o   = 1'b1;
        ctrl.bit_en     = 1'b1;
        ctrl.crc_en     = 1'b1;
        ctrl.crc_in_tdi = 1'b1;
        if (update_dr_i)
          state_d = ST_IDLE;
        else if (ctrl.last_bit)
        begin
          biu_strobe_o  = 1'b1;                            // Word complete
          ctrl.addr_inc = 1'b1;
          ctrl.bit_rst  = 1'b1;
          ctrl.cnt_dec  = !ctrl.word_zero;
          if (ctrl.word_zero)
            state_d = ST_WCRC;
        end
      end
      ST_WCRC:
      begin
        top_inhibit_o = 1'b1;
        ctrl.bit_en   = 1'b1;
        if (update_dr_i)
          state_d = ST_IDLE;
        else if (ctrl.bit_32)
        begin
          state_d      = ST_WMATCH;
          ctrl.tdo_sel = TDO_MATCH;                        // Host CRC fully shifted in
        end
      end
      ST_WMATCH:
      begin
        ctrl.tdo_sel  = TDO_MATCH;
        top_inhibit_o = 1'b1;
        if (update_dr_i)
          state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase

    // Word boundary of a read burst
    if (load_word)
    begin
      ctrl.out_ld      = 1'b1;
      ctrl.out_src_biu = 1'b1;
      ctrl.bit_rst     = 1'b1;
      ctrl.cnt_dec     = 1'b1;
      if (!ctrl.next_word_zero)
      begin
        biu_strobe_o  = 1'b1;                              // Prefetch the following word
        ctrl.addr_inc = 1'b1;
      end
    end
  end

  // Prefetched read word has to be back before the word boundary
  a_prefetch_ready: assert property (@(posedge tck_i) disable iff (tlr_i)
    (state_q == ST_RBURST && ctrl.last_bit && !ctrl.word_zero && !update_dr_i)
      |-> biu_ready_i)
    else $error("read word not ready at word boundary");

endmodule

/* dbg_cpu_module.sv */
//////////////////////////////
// JTAG CPU debug module
// SPR burst access and stall control for one core
//////////////////////////////
`timescale 1ns/1ps

module dbg_cpu_module (
  // TAP side
  input  logic                           tck_i,
  input  logic                           tlr_i,
  input  logic                           tdi_i,
  input  logic                           capture_dr_i,
  input  logic                           shift_dr_i,
  input  logic                           update_dr_i,
  input  logic                           module_select_i,
  input  logic [dbg_pkg::DR_LEN-1:0]     data_register_i,
  output logic                           module_tdo_o,
  output logic                           top_inhibit_o,
  // SPR bus
  output logic [dbg_pkg::CPU_ADDR_W-1:0] cpu_addr_o,
  output logic [dbg_pkg::WORD_W-1:0]     cpu_data_o,
  input  logic [dbg_pkg::WORD_W-1:0]     cpu_data_i,
  output logic                           cpu_stb_o,
  output logic                           cpu_we_o,
  input  logic                           cpu_ack_i,
  // Core control
  input  logic                           cpu_bp_i,
  output logic                           cpu_stall_o
);
  import dbg_pkg::*;

  logic              biu_strobe;
  logic              rd_op;
  logic              biu_ready;
  logic [ADDR_W-1:0] biu_addr;
  logic [WORD_W-1:0] biu_wdata;
  logic [WORD_W-1:0] biu_rdata;
  logic              stall_we;

  dbg_ctrl_if ctrl ();

  dbg_burst_fsm u_fsm (
    .tck_i           (tck_i),
    .tlr_i           (tlr_i),
    .capture_dr_i    (capture_dr_i),
    .shift_dr_i      (shift_dr_i),
    .update_dr_i     (update_dr_i),
    .module_select_i (module_select_i),
    .data_register_i (data_register_i),
    .ctrl            (ctrl.fsm),
    .biu_ready_i     (biu_ready),
    .biu_strobe_o    (biu_strobe),
    .rd_op_o         (rd_op),
    .stall_we_o      (stall_we),
    .top_inhibit_o   (top_inhibit_o)
  );

  dbg_datapath u_dp (
    .tck_i           (tck_i),
    .tlr_i           (tlr_i),
    .tdi_i           (tdi_i),
    .data_register_i (data_register_i),
    .ctrl            (ctrl.datapath),
    .status_i        (cpu_stall_o),
    .biu_rdata_i     (biu_rdata),
    .biu_ready_i     (biu_ready),
    .addr_o          (biu_addr),
    .wdata_o         (biu_wdata),
    .tdo_o           (module_tdo_o)
  );

  dbg_bus_unit u_biu (
    .tck_i      (tck_i),
    .tlr_i      (tlr_i),
    .strobe_i   (biu_strobe),
    .rd_i       (rd_op),
    .addr_i     (biu_addr),
    .wdata_i    (biu_wdata),
    .rdata_o    (biu_rdata),
    .ready_o    (biu_ready),
    .cpu_addr_o (cpu_addr_o),
    .cpu_data_o (cpu_data_o),
    .cpu_data_i (cpu_data_i),
    .cpu_stb_o  (cpu_stb_o),
    .cpu_we_o   (cpu_we_o),
    .cpu_ack_i  (cpu_ack_i)
  );

  // Stall value is the first bit below the opcode
  dbg_stall_reg u_stall (
    .tck_i   (tck_i),
    .tlr_i   (tlr_i),
    .we_i    (stall_we),
    .data_i  (data_register_i[ADDR_MSB]),
    .bp_i    (cpu_bp_i),
    .stall_o (cpu_stall_o)
  );

endmodule

/* tb_dbg_cpu_module.sv */
//////////////////////////////
// Debug module testbench
// TAP driver, SPR memory model, CRC model and pattern checks
//////////////////////////////
`timescale 1ns/1ps

module tb_dbg_cpu_module;
  import dbg_pkg::*;

  localparam int MAX_LINES = 64;

  logic                  tck_i;
  logic                  tlr_i;
  logic                  tdi_i;
  logic                  capture_dr_i;
  logic                  shift_dr_i;
  logic                  update_dr_i;
  logic                  module_select_i;
  logic [DR_LEN-1:0]     data_register_i;
  logic                  module_tdo_o;
  logic                  top_inhibit_o;
  logic [CPU_ADDR_W-1:0] cpu_addr_o;
  logic [WORD_W-1:0]     cpu_data_o;
  logic [WORD_W-1:0]     cpu_data_i = '0;     // Driven by the memory model
  logic                  cpu_stb_o;
  logic                  cpu_we_o;
  logic                  cpu_ack_i = 1'b0;
  logic                  cpu_bp_i;
  logic                  cpu_stall_o;

  // Pattern table, one entry per command line
  byte         kind_t [MAX_LINES];
  logic [31:0] addr_t [MAX_LINES];
  int          cnt_t  [MAX_LINES];
  int          lat_t  [MAX_LINES];
  int          bad_t  [MAX_LINES];
  int          stv_t  [MAX_LINES];

  int n_lines     = 0;
  int total_words = 0;
  int limit       = 0;                    // 0 until the patterns are read
  int cycles      = 0;
  int n_pass      = 0;
  int n_fail      = 0;
  int errs        = 0;                    // Errors in the running test
  int ack_lat     = 0;
  int wait_cnt    = 0;

  logic [31:0]       lfsr;
  logic [WORD_W-1:0] mem     [0:65535];   // SPR space seen by the bus
  logic [WORD_W-1:0] exp_mem [0:65535];   // Expected contents

  dbg_cpu_module UUT (.*);

  initial
  begin
    tck_i = 1'b0;
    forever #50 tck_i = ~tck_i;
  end

  // Run limit
  always @(posedge tck_i)
  begin
    cycles++;
    if (limit > 0 && cycles > limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", limit);
      $display("Verification failed");
      $finish;
    end
  end

  ////////////////////////////// SPR memory model
  always @(posedge tck_i)
  begin
    #10;
    if (cpu_ack_i)
      cpu_ack_i = 1'b0;                   // Single cycle ack
    else if (cpu_stb_o)
    begin
      if (wait_cnt >= ack_lat)
      begin
        wait_cnt  = 0;
        cpu_ack_i = 1'b1;
        if (cpu_we_o)
          mem[cpu_addr_o] = cpu_data_o;
        else
          cpu_data_i = mem[cpu_addr_o];
      end
      else
        wait_cnt++;
    end
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic next_random_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] random_word();
    logic [31:0] w;
    for (int b = 0; b < 32; b++)
      w[b] = next_random_bit();           // LSB taken first
    return w;
  endfunction

  // Reflected CRC-32 step, one bit
  function automatic logic [31:0] crc_step(input logic [31:0] c, input logic b);
    logic [31:0] r;
    r = {1'b0, c[31:1]};
    if (c[0] != b)
      r = r ^ 32'hEDB8_8320;              // Reflected CRC-32 polynomial
    return r;
  endfunction

  ////////////////////////////// TAP driver
  task automatic tick();
    @(posedge tck_i);
    #10;
  endtask

  task automatic send_command(input logic [3:0] opc, input logic [31:0] addr,
                              input logic [15:0] cnt);
    data_register_i = {1'b0, opc, addr, cnt};
    update_dr_i     = 1'b1;
    tick();
    update_dr_i     = 1'b0;
    tick();                               // Gap before capture
  endtask

  task automatic capture_dr();
    data_register_i = '0;
    capture_dr_i    = 1'b1;
    tick();
    capture_dr_i    = 1'b0;
  endtask

  // One shift cycle, TDO sampled at the falling edge
  task automatic shift_bit(input logic b, input logic exp_inh, output logic tdo);
    shift_dr_i = 1'b1;
    tdi_i      = b;
    @(negedge tck_i);
    tdo = module_tdo_o;
    if (top_inhibit_o !== exp_inh)
    begin
      $display("error at %0t: top_inhibit_o %b, expected %b", $time, top_inhibit_o, exp_inh);
      errs++;
    end
    tick();
    data_register_i = {b, data_register_i[DR_LEN-1:1]};  // TDI enters at the MSB
  endtask

  task automatic close_burst();
    shift_dr_i  = 1'b0;
    update_dr_i = 1'b1;
    tick();
    update_dr_i = 1'b0;
    @(negedge tck_i);
    if (top_inhibit_o !== 1'b0)
    begin
      $display("error at %0t: top_inhibit_o still high after update", $time);
      errs++;
    end
    tick();
  endtask

  ////////////////////////////// Tests
  task automatic run_write(input logic [31:0] addr, input int cnt, input int bad);
    logic [31:0] words [$];
    logic [31:0] crc;
    logic [31:0] w;
    logic        t;
    crc = 32'hFFFF_FFFF;
    send_command(BWRITE32, addr, 16'(cnt));
    capture_dr();
    shift_bit(1'b1, 1'b1, t);             // Start bit
    for (int i = 0; i < cnt; i++)
    begin
      w = random_word();
      words.push_back(w);
      for (int b = 0; b < 32; b++)
      begin
        crc = crc_step(crc, w[b]);
        shift_bit(w[b], 1'b1, t);
      end
    end
    if (bad != 0)
      crc = crc ^ 32'h1;                  // Corrupt one CRC bit
    for (int b = 0; b < 32; b++)
      shift_bit(crc[b], 1'b1, t);
    shift_dr_i = 1'b0;
    for (int k = 0; k < 2; k++)
    begin
      @(negedge tck_i);
      if (module_tdo_o !== (bad == 0))
      begin
        $display("error at %0t: CRC match bit %b, bad flag %0d", $time, module_tdo_o, bad);
        errs++;
      end
      tick();
    end
    close_burst();
    for (int i = 0; i < cnt; i++)
    begin
      exp_mem[16'(addr + i)] = words[i];
      if (mem[16'(addr + i)] !== words[i])
      begin
        $display("error at %0t: mem[%h] = %h, expected %h", $time, 16'(addr + i),
                 mem[16'(addr + i)], words[i]);
        errs++;
      end
    end
  endtask

  task automatic run_read(input logic [31:0] addr, input int cnt);
    logic [31:0] crc;
    logic [31:0] got;
    logic [31:0] exp;
    logic        t;
    int          polls;
    crc   = 32'hFFFF_FFFF;
    polls = 0;
    send_command(BREAD32, addr, 16'(cnt));
    capture_dr();
    do
    begin
      shift_bit(1'b0, 1'b1, t);           // Ready bit
      polls++;
    end
    while (!t && polls < 200);
    if (!t)
    begin
      $display("Read at %h never became ready", addr);
      errs++;
    end
    else
    begin
      for (int i = 0; i < cnt; i++)
      begin
        exp = exp_mem[16'(addr + i)];
        for (int b = 0; b < 32; b++)
        begin
          shift_bit(1'b0, 1'b1, t);
          got[b] = t;
          crc    = crc_step(crc, exp[b]);
        end
        if (got !== exp)
        begin
          $display("error at %0t: read word %0d = %h, expected %h", $time, i, got, exp);
          errs++;
        end
      end
      for (int b = 0; b < 32; b++)
      begin
        shift_bit(1'b0, 1'b1, t);
        got[b] = t;
      end
      if (got !== crc)
      begin
        $display("error at %0t: read CRC %h, expected %h", $time, got, crc);
        errs++;
      end
    end
    close_burst();
  endtask

  task automatic run_stall_write(input logic v);
    logic t;
    send_command(IREG_WR, {v, 31'h0}, 16'h0);
    @(negedge tck_i);
    if (cpu_stall_o !== v)
    begin
      $display("error at %0t: cpu_stall_o %b, expected %b", $time, cpu_stall_o, v);
      errs++;
    end
    tick();
    capture_dr();                         // Status read in idle
    for (int b = 0; b < 8; b++)
    begin
      shift_bit(1'b0, 1'b0, t);
      if (t !== (b == 0 ? v : 1'b0))
      begin
        $display("error at %0t: status bit %0d is %b", $time, b, t);
        errs++;
      end
    end
    shift_dr_i = 1'b0;
  endtask

  task automatic run_breakpoint();
    send_command(IREG_WR, 32'h0, 16'h0);  // Core released before the breakpoint
    @(negedge tck_i);
    if (cpu_stall_o !== 1'b0)
    begin
      $display("error at %0t: cpu_stall_o not cleared before breakpoint", $time);
      errs++;
    end
    tick();
    cpu_bp_i = 1'b1;
    tick();
    cpu_bp_i = 1'b0;
    @(negedge tck_i);
    if (cpu_stall_o !== 1'b1)
    begin
      $display("error at %0t: breakpoint did not set cpu_stall_o", $time);
      errs++;
    end
    tick();
  endtask

  task automatic read_patterns();
    int    fd;
    string line;
    byte   k;
    logic [31:0] a;
    int    c;
    int    l;
    int    bd;
    int    sv;
    fd = $fopen("dbg_patterns.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open dbg_patterns.txt");
      n_fail++;
    end
    else
    begin
      while (!$feof(fd) && n_lines < MAX_LINES)
      begin
        if ($fgets(line, fd) != 0)
        begin
          if ($sscanf(line, "%c %h %d %d %d %d", k, a, c, l, bd, sv) == 6 && k != "#")
          begin
            kind_t[n_lines] = k;
            addr_t[n_lines] = a;
            cnt_t[n_lines]  = c;
            lat_t[n_lines]  = l;
            bad_t[n_lines]  = bd;
            stv_t[n_lines]  = sv;
            total_words    += c;
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////// Main sequence
  initial
  begin
    tlr_i           = 1'b1;
    tdi_i           = 1'b0;
    capture_dr_i    = 1'b0;
    shift_dr_i      = 1'b0;
    update_dr_i     = 1'b0;
    module_select_i = 1'b1;               // Only module on the chain
    data_register_i = '0;
    cpu_bp_i        = 1'b0;
    lfsr            = 32'h8a88_6c98;
    for (int a = 0; a < 65536; a++)
    begin
      mem[a]     = {16'(a) ^ 16'hc3a5, ~16'(a)};   // Fill tied to every address bit
      exp_mem[a] = mem[a];
    end
    read_patterns();
    limit = 4000 + 200 * (total_words + n_lines);

    repeat (5) @(posedge tck_i);
    #10;
    tlr_i = 1'b0;
    errs  = 0;
    @(negedge tck_i);
    if ({module_tdo_o, top_inhibit_o, cpu_stb_o, cpu_we_o, cpu_stall_o} !== 5'b0)
    begin
      $display("error at %0t: control outputs not zero after reset", $time);
      errs++;
    end
    if (errs == 0)
      n_pass++;
    else
      n_fail++;
    $display("test 0 reset: %s", errs == 0 ? "ok" : "FAILED");
    tick();

    for (int i = 0; i < n_lines; i++)
    begin
      errs    = 0;
      ack_lat = lat_t[i];
      case (kind_t[i])
        "W": run_write(addr_t[i], cnt_t[i], bad_t[i]);
        "R": run_read(addr_t[i], cnt_t[i]);
        "S": run_stall_write(stv_t[i] != 0);
        "P": run_breakpoint();
        default:
        begin
          $display("Unknown command kind on pattern line %0d", i + 1);
          errs++;
        end
      endcase
      if (errs == 0)
        n_pass++;
      else
        n_fail++;
      $display("test %0d %c %h: %s", i + 1, kind_t[i], addr_t[i], errs == 0 ? "ok" : "FAILED");
      repeat (2) tick();
    end

    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

/* dbg_patterns.txt */
# kind addr(hex) count ack_latency bad_crc stall
# W write burst, R read burst, S stall write, P breakpoint pulse
P 0000 0 0 0 1
S 0000 0 0 0 0
S 0000 0 0 0 1
S 0000 0 0 0 0
W 0100 4 2 0 0
R 0100 4 15 0 0
W 0200 1 0 0 0
W 0300 3 20 1 0
R 0300 3 20 0 0
R 0200 1 0 0 0
W 1234 8 5 0 0
R 1234 8 1 0 0
R 0102 2 18 0 0
W fffe 2 3 0 0
R fffe 2 7 0 0
R 5000 2 4 0 0
S 0000 0 0 0 1
P 0000 0 0 0 1
S 0000 0 0 0 0
W 0020 16 10 0 0
R 0020 16 12 0 0
W 0400 2 19 1 0
R 0400 2 0 0 0
P 0000 0 0 0 1
S 0000 0 0 0 0

/* files.f */
dbg_pkg.sv
dbg_ctrl_if.sv
dbg_crc32.sv
dbg_bus_unit.sv
dbg_stall_reg.sv
dbg_datapath.sv
dbg_burst_fsm.sv
dbg_cpu_module.sv
tb_dbg_cpu_module.sv

/* run_sim.sh */
#!/bin/sh
# Build the debug module testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module tb_dbg_cpu_module -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "Verification passed" \
  && echo "run_sim: simulation ok" \
  || { echo "run_sim: simulation reported failure"; exit 1; }
